// File: project.f
+incdir+bench
verilog/list_sel_pkg.sv
verilog/list_sel_enq.sv
verilog/list_sel_mem_rf_pg.sv
verilog/list_sel_deq.sv
verilog/list_sel_top.sv
bench/list_sel_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the list store testbench with Verilator and runs it.
# The exit status is non-zero when the log reports a failure.

set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f project.f \
    --top-module list_sel_tb \
    -Mdir obj_dir \
    -o list_sel_sim

./obj_dir/list_sel_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "Testbench reported a failure"
    exit 1
fi

echo "Testbench run complete"

// File: bench/list_sel_tb_tests.svh
// Directed tests for the list store, included into the testbench module

`ifndef LIST_SEL_TB_TESTS_SVH
`define LIST_SEL_TB_TESTS_SVH

    // Flags after reset, then a pop on the empty list that must not return anything
    task automatic reset_defaults();
        test_name = "reset_defaults";
        run_cycle(1'b0, '0, 1'b0);
        run_cycle(1'b0, '0, 1'b1);
        run_cycle(1'b0, '0, 1'b0);
    endtask

    // One entry in, popped in the next cycle, valid for exactly one cycle
    task automatic single_round_trip();
        entry_t value;
        test_name = "single_round_trip";
        random_entry(value);
        run_cycle(1'b1, value, 1'b0);
        run_cycle(1'b0, '0, 1'b1);
        run_cycle(1'b0, '0, 1'b0);
        run_cycle(1'b0, '0, 1'b0);
    endtask

    // Fill to full, try one more push, then drain back to back
    task automatic fill_and_drain();
        entry_t value;
        test_name = "fill_and_drain";
        for (int i = 0; i <= LIST_DEPTH; i++) begin
            random_entry(value);
            run_cycle(1'b1, value, 1'b0);
        end
        repeat (LIST_DEPTH) run_cycle(1'b0, '0, 1'b1);
        run_cycle(1'b0, '0, 1'b0);
    endtask

    // Half full list with a push and a pop in every cycle keeps its level
    task automatic concurrent_traffic();
        entry_t value;
        test_name = "concurrent_traffic";
        for (int i = 0; i < LIST_DEPTH / 2; i++) begin
            random_entry(value);
            run_cycle(1'b1, value, 1'b0);
        end
        for (int i = 0; i < 20; i++) begin
            random_entry(value);
            run_cycle(1'b1, value, 1'b1);
        end
        repeat (LIST_DEPTH / 2) run_cycle(1'b0, '0, 1'b1);
        run_cycle(1'b0, '0, 1'b0);
    endtask

    // Isolated pop still consumes its entry, the next one comes back intact
    task automatic isolation_clamp();
        entry_t value;
        test_name = "isolation_clamp";
        for (int i = 0; i < 2; i++) begin
            random_entry(value);
            run_cycle(1'b1, value, 1'b0);
        end
        isol_req = 1'b1;
        run_cycle(1'b0, '0, 1'b1);
        run_cycle(1'b0, '0, 1'b0);
        isol_req = 1'b0;
        run_cycle(1'b0, '0, 1'b1);
        run_cycle(1'b0, '0, 1'b0);
    endtask

    // Entries from before and during power-off return as zero, later ones survive
    task automatic power_cycle();
        entry_t value;
        test_name = "power_cycle";
        for (int i = 0; i < 3; i++) begin
            random_entry(value);
            run_cycle(1'b1, value, 1'b0);
        end
        // The acknowledge is checked every cycle against the delayed request
        pwr_req = 1'b1;
        repeat (3) run_cycle(1'b0, '0, 1'b0);
        for (int i = 0; i < 2; i++) begin
            random_entry(value);
            run_cycle(1'b1, value, 1'b0);
        end
        pwr_req = 1'b0;
        repeat (3) run_cycle(1'b0, '0, 1'b0);
        random_entry(value);
        run_cycle(1'b1, value, 1'b0);
        repeat (6) run_cycle(1'b0, '0, 1'b1);
        run_cycle(1'b0, '0, 1'b0);
    endtask

`endif

// File: bench/list_sel_tb.sv
// Testbench top for the list store with clock, reset, timeout, LFSR, scoreboard and checks

`timescale 1ns/1ps

module list_sel_tb;

    import list_sel_pkg::*;

    // Power acknowledge delay used by the DUT and by the model
    localparam int PG_DELAY       = 2;
    // The directed tests run for a few hundred cycles
    localparam int TIMEOUT_CYCLES = 2000;

    logic   clk;
    logic   rst;
    logic   push;
    entry_t push_data;
    logic   pop;
    logic   pgcb_isol_en;
    logic   pwr_enable_b_in;
    logic   full;
    logic   empty;
    logic   pop_valid;
    entry_t pop_data;
    logic   pwr_enable_b_out;

    // Reference list and the pop result expected in the following cycle
    entry_t ref_q[$];
    logic   pend_valid;
    entry_t pend_data;

    // Power model with the request history and the off state one cycle back
    logic [PG_DELAY-1:0] pwr_hist;
    logic                off_prev;

    // Levels the tests ask for, applied at the next drive point
    logic        isol_req;
    logic        pwr_req;
    logic [31:0] lfsr_state;
    string       test_name;
    int          check_count;
    int          error_count;
    int          cycle_count;

    list_sel_top #(
        .PG_DELAY         (PG_DELAY)
    ) dut (
         .clk              (clk)
        ,.rst              (rst)
        ,.push             (push)
        ,.push_data        (push_data)
        ,.full             (full)
        ,.pop              (pop)
        ,.empty            (empty)
        ,.pop_valid        (pop_valid)
        ,.pop_data         (pop_data)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    // ------------------------------------------------------------------------
    // Clock and timeout
    // ------------------------------------------------------------------------

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("ERROR: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
        end
    endtask

    // Taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // One LFSR step per entry bit
    task automatic random_entry(output entry_t value);
        for (int b = 0; b < ENTRY_W; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value[b]   = lfsr_state[0];
        end
    endtask

    // Drives one cycle, checks what the DUT shows in it and steps the model
    task automatic run_cycle(input logic push_en, input entry_t data, input logic pop_en);
        logic   pop_ok;
        logic   push_ok;
        logic   exp_off;
        entry_t exp_data;
        @(posedge clk);
        #1;
        push            = push_en;
        push_data       = data;
        pop             = pop_en;
        pgcb_isol_en    = isol_req;
        pwr_enable_b_in = pwr_req;
        #1;
        exp_off  = pwr_hist[PG_DELAY-1];
        // Isolation clamps the data in the cycle it is shown
        exp_data = pgcb_isol_en ? entry_t'(0) : pend_data;
        check_value("pop_valid", 32'(pend_valid), 32'(pop_valid));
        if (pend_valid) begin
            check_value("pop_data", 32'(exp_data), 32'(pop_data));
        end
        check_value("full", 32'(ref_q.size() == LIST_DEPTH), 32'(full));
        check_value("empty", 32'(ref_q.size() == 0), 32'(empty));
        check_value("pwr_enable_b_out", 32'(exp_off), 32'(pwr_enable_b_out));
        // Both flags come from the state at the start of the cycle
        pop_ok     = pop_en && (ref_q.size() != 0);
        push_ok    = push_en && (ref_q.size() != LIST_DEPTH);
        pend_valid = pop_ok;
        if (pop_ok) begin
            pend_data = ref_q.pop_front();
        end
        // A write while off is dropped and the row keeps its cleared value
        if (push_ok) begin
            ref_q.push_back(exp_off ? entry_t'(0) : data);
        end
        // The first off cycle wipes every stored entry
        if (exp_off && !off_prev) begin
            for (int i = 0; i < ref_q.size(); i++) begin
                ref_q[i] = '0;
            end
        end
        off_prev = exp_off;
        pwr_hist = {pwr_hist[PG_DELAY-2:0], pwr_req};
    endtask

`include "list_sel_tb_tests.svh"

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------

    initial begin
        rst             = 1'b1;
        push            = 1'b0;
        push_data       = '0;
        pop             = 1'b0;
        pgcb_isol_en    = 1'b0;
        pwr_enable_b_in = 1'b0;
        pend_valid      = 1'b0;
        pend_data       = '0;
        pwr_hist        = '0;
        off_prev        = 1'b0;
        isol_req        = 1'b0;
        pwr_req         = 1'b0;
        lfsr_state      = 32'h84bd_8684;
        test_name       = "reset";
        check_count     = 0;
        error_count     = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_defaults();
        single_round_trip();
        fill_and_drain();
        concurrent_traffic();
        isolation_clamp();
        power_cycle();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog/list_sel_top.sv
// Top level of the list store joining producer, power-gated buffer and consumer

`timescale 1ns/1ps

module list_sel_top #(
    // Power acknowledge delay handed to the buffer
    parameter int PG_DELAY = 2
) (
     input  logic                 clk
    ,input  logic                 rst

    // Producer side
    ,input  logic                 push
    ,input  list_sel_pkg::entry_t push_data
    ,output logic                 full

    // Consumer side
    ,input  logic                 pop
    ,output logic                 empty
    ,output logic                 pop_valid
    ,output list_sel_pkg::entry_t pop_data

    // Power management pins go straight to the buffer
    ,input  logic                 pgcb_isol_en
    ,input  logic                 pwr_enable_b_in
    ,output logic                 pwr_enable_b_out
);

    import list_sel_pkg::*;

    // ------------------------------------------------------------------------
    // Internal connections
    // ------------------------------------------------------------------------

    // Write and read requests into the register file
    mem_wr_t wr_req;
    mem_rd_t rd_req;

    // Read data back to the consumer
    entry_t  rdata;

    // Pointers exchanged between producer and consumer
    ptr_t    tail;
    ptr_t    head;

    // Producer owns the tail and the full flag
    list_sel_enq u_enq (
         .clk              (clk)
        ,.rst              (rst)
        ,.push             (push)
        ,.push_data        (push_data)
        ,.head             (head)
        ,.full             (full)
        ,.tail             (tail)
        ,.wr_req           (wr_req)
    );

    // Storage with its power-gating behaviour
    list_sel_mem_rf_pg #(
        .PG_DELAY          (PG_DELAY)
    ) u_mem (
         .clk              (clk)
        ,.rst              (rst)
        ,.wr_req           (wr_req)
        ,.rd_req           (rd_req)
        ,.rdata            (rdata)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    // Consumer owns the head and the empty flag
    list_sel_deq u_deq (
         .clk              (clk)
        ,.rst              (rst)
        ,.pop              (pop)
        ,.tail             (tail)
        ,.empty            (empty)
        ,.head             (head)
        ,.rd_req           (rd_req)
        ,.rdata            (rdata)
        ,.pop_valid        (pop_valid)
        ,.pop_data         (pop_data)
    );

endmodule

// File: verilog/list_sel_deq.sv
// Consumer side of the list with head pointer, empty flag, read request and pop return

`timescale 1ns/1ps

module list_sel_deq (
     input  logic                  clk
    ,input  logic                  rst

    // Pop strobe from the user side
    ,input  logic                  pop

    // Tail pointer comes over from the producer
    ,input  list_sel_pkg::ptr_t    tail

    ,output logic                  empty
    ,output list_sel_pkg::ptr_t    head

    // Read request and returned data from the register file
    ,output list_sel_pkg::mem_rd_t rd_req
    ,input  list_sel_pkg::entry_t  rdata

    // Popped entry, valid for exactly one cycle
    ,output logic                  pop_valid
    ,output list_sel_pkg::entry_t  pop_data
);

    import list_sel_pkg::*;

    // ------------------------------------------------------------------------
    // Empty detection
    // ------------------------------------------------------------------------

    // Row part of the head pointer
    addr_t head_row;

    // A pop is accepted only while something is stored
    logic  pop_go;

    assign head_row = head[ADDR_W-1:0];

    // Equal pointers including the wrap bit mean nothing is stored
    assign empty = (head == tail);

    // A pop on an empty list is dropped even if a push lands this cycle
    assign pop_go = pop && !empty;

    // ------------------------------------------------------------------------
    // Read request
    // ------------------------------------------------------------------------

    // The read goes out in the pop cycle so data returns one cycle later
    always_comb begin
        rd_req.re    = pop_go;
        rd_req.raddr = head_row;
    end

    // ------------------------------------------------------------------------
    // Head pointer and pop return
    // ------------------------------------------------------------------------

    // The head moves at the same edge that launches the read, so back to
    // back pops keep one read in flight per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            head      <= '0;
            pop_valid <= 1'b0;
        end else begin
            pop_valid <= pop_go;
            if (pop_go) begin
                head <= head + ptr_t'(1);
            end
        end
    end

    // The memory output already lines up with the valid pulse
    assign pop_data = rdata;

endmodule

// File: verilog/list_sel_mem_rf_pg.sv
// Power-gated 64x13 two-port register file with registered read, isolation and power-ack chain

`timescale 1ns/1ps

module list_sel_mem_rf_pg #(
    // Cycles from a power request to its acknowledge
    parameter int PG_DELAY = 2
) (
     input  logic                  clk
    ,input  logic                  rst

    // Write and read ports on the shared clock
    ,input  list_sel_pkg::mem_wr_t wr_req
    ,input  list_sel_pkg::mem_rd_t rd_req
    ,output list_sel_pkg::entry_t  rdata

    // Power management interface
    ,input  logic                  pgcb_isol_en
    ,input  logic                  pwr_enable_b_in
    ,output logic                  pwr_enable_b_out
);

    import list_sel_pkg::*;

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------

    // The array itself
    entry_t mem [LIST_DEPTH];

    // Registered read data before isolation
    entry_t rdata_q;

    // Power acknowledge shift chain
    logic [PG_DELAY-1:0] pg_chain;

    // Off state seen one cycle back, used to find the first off cycle
    logic pwr_off_q;

    // High in the first cycle the array is powered off
    logic pwr_off_first;

    // ------------------------------------------------------------------------
    // Power sequencing
    // ------------------------------------------------------------------------

    // The request walks through PG_DELAY flops before it is acknowledged
    always_ff @(posedge clk) begin
        if (rst) begin
            pg_chain  <= '0;
            pwr_off_q <= 1'b0;
        end else begin
            pg_chain[0] <= pwr_enable_b_in;
            for (int i = 1; i < PG_DELAY; i++) begin
                pg_chain[i] <= pg_chain[i-1];
            end
            pwr_off_q <= pwr_enable_b_out;
        end
    end

    // The array counts as off for as long as the acknowledge is high
    assign pwr_enable_b_out = pg_chain[PG_DELAY-1];
    assign pwr_off_first    = pwr_enable_b_out && !pwr_off_q;

    // ------------------------------------------------------------------------
    // Array write and power-down loss
    // ------------------------------------------------------------------------

    // Contents are lost when power drops, modelled here as all zero
    always_ff @(posedge clk) begin
        if (pwr_off_first) begin
            for (int r = 0; r < LIST_DEPTH; r++) begin
                mem[r] <= '0;
            end
        end else if (wr_req.we && !pwr_enable_b_out) begin
            // writes while off are dropped
            mem[wr_req.waddr] <= wr_req.wdata;
        end
    end

    // ------------------------------------------------------------------------
    // Registered read and isolation
    // ------------------------------------------------------------------------

    // Read data shows up in the cycle after the read request
    always_ff @(posedge clk) begin
        if (rd_req.re) begin
            rdata_q <= mem[rd_req.raddr];
        end
    end

    // Isolation clamps the output to zero whatever the register holds
    assign rdata = pgcb_isol_en ? '0 : rdata_q;

endmodule

// File: verilog/list_sel_enq.sv
// Producer side of the list with tail pointer, full flag and memory write request

`timescale 1ns/1ps

module list_sel_enq (
     input  logic                 clk
    ,input  logic                 rst

    // Push strobe and the entry that goes with it
    ,input  logic                 push
    ,input  list_sel_pkg::entry_t push_data

    // Head pointer comes back from the consumer
    ,input  list_sel_pkg::ptr_t   head

    ,output logic                 full
    ,output list_sel_pkg::ptr_t   tail

    // Write request straight into the register file
    ,output list_sel_pkg::mem_wr_t wr_req
);

    import list_sel_pkg::*;

    // ------------------------------------------------------------------------
    // Full detection
    // ------------------------------------------------------------------------

    // Row part of each pointer
    addr_t tail_row;
    addr_t head_row;

    // A push is accepted only while the list has room
    logic  push_go;

    assign tail_row = tail[ADDR_W-1:0];
    assign head_row = head[ADDR_W-1:0];

    // Same row with different wrap bits means the tail has lapped the head
    assign full = (tail_row == head_row) && (tail[ADDR_W] != head[ADDR_W]);

    // A push strobe while full is silently dropped
    assign push_go = push && !full;

    // ------------------------------------------------------------------------
    // Write request
    // ------------------------------------------------------------------------

    // The request is combinational from the strobe so the row is written
    // at the same edge that moves the tail
    always_comb begin
        wr_req.we    = push_go;
        wr_req.waddr = tail_row;
        wr_req.wdata = push_data;
    end

    // ------------------------------------------------------------------------
    // Tail pointer
    // ------------------------------------------------------------------------

    // The wrap bit toggles naturally when the row bits roll over
    always_ff @(posedge clk) begin
        if (rst) begin
            tail <= '0;
        end else if (push_go) begin
            tail <= tail + ptr_t'(1);
        end
    end

endmodule

// File: verilog/list_sel_pkg.sv
// Entry, address and pointer types plus write and read request structs for the list store

package list_sel_pkg;

    // ------------------------------------------------------------------------
    // Widths and depth
    // ------------------------------------------------------------------------

    // Each stored list entry is thirteen bits wide
    localparam int ENTRY_W    = 13;

    // Number of rows in the power-gated register file
    localparam int LIST_DEPTH = 64;

    // The row address width follows from the depth
    localparam int ADDR_W     = $clog2(LIST_DEPTH);

    // One stored entry
    typedef logic [ENTRY_W-1:0] entry_t;

    // A register-file row address
    typedef logic [ADDR_W-1:0]  addr_t;

    // List pointer with one wrap bit above the row bits so full and empty differ
    typedef logic [ADDR_W:0]    ptr_t;

    // ------------------------------------------------------------------------
    // Memory port requests
    // ------------------------------------------------------------------------

    // Write port request, twenty bits in all
    typedef struct packed {
        logic   we;
        addr_t  waddr;
        entry_t wdata;
    } mem_wr_t;

    // Read port request, seven bits in all
    typedef struct packed {
        logic   re;
        addr_t  raddr;
    } mem_rd_t;

endpackage
